/* cache_pkg.sv */
package cache_pkg;

   // address and data geometry
   localparam int addr_w  = 16;
   localparam int data_w  = 16;
   localparam int index_w = 6;                   // 64 lines
   localparam int tag_w   = addr_w - index_w;

   // field view of an address with the tag in the upper bits
   typedef struct packed {
      logic [tag_w-1:0]   tag;
      logic [index_w-1:0] index;
   } cache_addr_t;

   // the memory sees a flat word address
   // the cache splits the same word into tag and index
   typedef union packed {
      logic [addr_w-1:0] raw;
      cache_addr_t       fields;
   } cache_addr_u;

   typedef logic [data_w-1:0] data_t;

   typedef logic [15:0] perf_cnt_t;             // wraps at 16 bits

endpackage

/* cache_array_if.sv */
`timescale 1ns/1ns
interface cache_array_if import cache_pkg::*; ();

   // address fields and write data from the controller
   logic [index_w-1:0] index;
   logic [tag_w-1:0]   tag_in;
   data_t              wdata;

   // controls
   logic comp;          // compare tag_in against the stored tag
   logic write;         // write entry at index on this edge
   logic valid_in;
   logic dirty_in;

   // status is combinational from index and tag_in
   logic               hit;
   logic               valid;
   logic               dirty;
   logic [tag_w-1:0]   victim_tag;
   data_t              rdata;

   modport ctrl (
      output index, tag_in, wdata, comp, write, valid_in, dirty_in,
      input  hit, valid, dirty, victim_tag, rdata
   );

   modport array (
      input  index, tag_in, wdata, comp, write, valid_in, dirty_in,
      output hit, valid, dirty, victim_tag, rdata
   );

endinterface

/* cache_array.sv */
`timescale 1ns/1ns
module cache_array import cache_pkg::*; (
   input logic          clk,
   input logic          arst_n,
   cache_array_if.array arr
);

   localparam int num_lines = 2**index_w;

   logic [tag_w-1:0]     tag_mem [num_lines];
   data_t                data_mem [num_lines];
   logic [num_lines-1:0] dirty_mem;
   logic [num_lines-1:0] valid_r;
   logic                 tag_eq;

   // lookup of the addressed entry
   assign tag_eq         = (tag_mem[arr.index] == arr.tag_in);
   assign arr.valid      = valid_r[arr.index];
   assign arr.dirty      = valid_r[arr.index] && dirty_mem[arr.index];  // masked when invalid
   assign arr.victim_tag = tag_mem[arr.index];
   assign arr.rdata      = data_mem[arr.index];

   // hit only counts during a compare
   assign arr.hit = arr.comp && arr.valid && tag_eq;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         valid_r <= '0;                          // whole cache empty
      else if (arr.write)
         valid_r[arr.index] <= arr.valid_in;
   end

   // tag, dirty and data follow the same write strobe
   always_ff @(posedge clk) begin
      if (arr.write) begin
         tag_mem[arr.index]   <= arr.tag_in;
         data_mem[arr.index]  <= arr.wdata;
         dirty_mem[arr.index] <= arr.dirty_in;
      end
   end

   a_write_index_known: assert property (@(posedge clk) disable iff (!arst_n)
      arr.write |-> !$isunknown(arr.index));

endmodule

/* backing_mem.sv */
`timescale 1ns/1ns
module backing_mem import cache_pkg::*; #(
   parameter int MEM_LAT = 4
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        mem_rd,
   input  logic        mem_wr,
   input  cache_addr_u mem_addr,
   input  data_t       mem_wdata,
   output data_t       mem_rdata,
   output logic        mem_stall
);

   localparam int depth = 2**addr_w;
   localparam int cnt_w = $clog2(MEM_LAT + 1);

   data_t            mem [depth];
   data_t            rdata_r;
   logic [cnt_w-1:0] lat_cnt;      // cycles left before the access completes
   logic             strobe;

   assign strobe = mem_rd || mem_wr;

   // every word starts out holding its own address
   initial begin
      for (int i = 0; i < depth; i++)
         mem[i] = data_t'(i);
   end

   always @(posedge clk) begin
      if (mem_wr)
         mem[mem_addr.raw] <= mem_wdata;         // write lands at the strobe
   end

   always_ff @(posedge clk) begin
      if (mem_rd)
         rdata_r <= mem[mem_addr.raw];
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         lat_cnt <= '0;
      else if (strobe)
         lat_cnt <= cnt_w'(MEM_LAT);
      else if (lat_cnt != '0)
         lat_cnt <= lat_cnt - 1'b1;
   end

   assign mem_stall = (lat_cnt != '0);
   assign mem_rdata = rdata_r;                  // good once stall drops

   initial assert (MEM_LAT >= 1)
      else $error("backing_mem: MEM_LAT must be at least 1");

   a_no_strobe_busy: assert property (@(posedge clk) disable iff (!arst_n)
      strobe |-> (lat_cnt == '0));

endmodule

/* cache_perf.sv */
`timescale 1ns/1ns
module cache_perf import cache_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      ev_hit,
   input  logic      ev_miss,
   input  logic      ev_wb,
   output perf_cnt_t hit_cnt,
   output perf_cnt_t miss_cnt,
   output perf_cnt_t wb_cnt
);

   localparam int num_ev = 3;

   logic [num_ev-1:0] ev;
   perf_cnt_t         cnt [num_ev];

   assign ev = {ev_wb, ev_miss, ev_hit};

   // one wrapping counter per event line
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < num_ev; i++)
            cnt[i] <= '0;
      end else begin
         for (int i = 0; i < num_ev; i++)
            if (ev[i])
               cnt[i] <= cnt[i] + 1'b1;
      end
   end

   assign hit_cnt  = cnt[0];
   assign miss_cnt = cnt[1];
   assign wb_cnt   = cnt[2];

endmodule

/* cache_ctrl.sv */
`timescale 1ns/1ns
module cache_ctrl import cache_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        rd,
   input  logic        wr,
   input  cache_addr_u addr,
   input  data_t       wdata,
   output data_t       rdata,
   output logic        done,
   output logic        was_hit,
   cache_array_if.ctrl arr,
   output logic        mem_rd,
   output logic        mem_wr,
   output cache_addr_u mem_addr,
   output data_t       mem_wdata,
   input  data_t       mem_rdata,
   input  logic        mem_stall,
   output logic        ev_hit,
   output logic        ev_miss,
   output logic        ev_wb
);

   localparam logic [2:0] st_idle           = 3'd0;
   localparam logic [2:0] st_compare_read   = 3'd1;
   localparam logic [2:0] st_compare_write  = 3'd2;
   localparam logic [2:0] st_writeback_wait = 3'd3;
   localparam logic [2:0] st_fetch_wait     = 3'd4;
   localparam logic [2:0] st_fill           = 3'd5;
   localparam logic [2:0] st_done           = 3'd6;

   logic [2:0]  state;
   logic [2:0]  next_state;
   logic        accept;
   logic        op_rd;          // current request is a read
   logic        mem_sent;       // strobe issued, memory still owes an answer
   logic        mem_ready;
   logic        victim_dirty;
   logic        hit_r;
   cache_addr_u addr_r;
   data_t       wdata_r;
   data_t       rdata_r;

   assign accept       = (state == st_idle) && (rd || wr);
   assign mem_ready    = mem_sent && !mem_stall;
   assign victim_dirty = arr.valid && arr.dirty;

   // array side, always addressed by the captured request
   assign arr.index  = addr_r.fields.index;
   assign arr.tag_in = addr_r.fields.tag;
   assign arr.wdata  = op_rd ? mem_rdata : wdata_r;   // fetched line or cpu data
   assign arr.comp   = (state == st_compare_read) || (state == st_compare_write);

   // write-back goes to the victim's address, fetch to the request's
   always_comb begin
      mem_addr = addr_r;
      if (state == st_writeback_wait)
         mem_addr.fields.tag = arr.victim_tag;
   end
   assign mem_wdata = arr.rdata;   // old line data

   assign rdata   = rdata_r;
   assign was_hit = hit_r;
   assign ev_wb   = mem_wr;        // every write strobe is an eviction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= st_idle;
         op_rd    <= 1'b0;
         mem_sent <= 1'b0;
         hit_r    <= 1'b0;
      end else begin
         state <= next_state;
         if (accept)
            op_rd <= rd;                         // rd wins over wr
         if (mem_rd || mem_wr)
            mem_sent <= 1'b1;
         else if (mem_ready)
            mem_sent <= 1'b0;
         if (arr.comp)
            hit_r <= arr.hit;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_r  <= addr;
         wdata_r <= wdata;
      end
      if (state == st_compare_read && arr.hit)
         rdata_r <= arr.rdata;
      if (state == st_fill && op_rd)
         rdata_r <= mem_rdata;
   end

   always_comb begin
      next_state   = state;
      arr.write    = 1'b0;
      arr.valid_in = 1'b0;
      arr.dirty_in = 1'b0;
      mem_rd       = 1'b0;
      mem_wr       = 1'b0;
      done         = 1'b0;
      ev_hit       = 1'b0;
      ev_miss      = 1'b0;

      case (state)
         st_idle: begin
            if (rd)
               next_state = st_compare_read;
            else if (wr)
               next_state = st_compare_write;
         end

         st_compare_read: begin
            if (arr.hit) begin
               ev_hit     = 1'b1;
               next_state = st_done;
            end else begin
               ev_miss    = 1'b1;
               next_state = victim_dirty ? st_writeback_wait : st_fetch_wait;
            end
         end

         st_compare_write: begin
            if (arr.hit) begin
               ev_hit       = 1'b1;
               arr.write    = 1'b1;
               arr.valid_in = 1'b1;
               arr.dirty_in = 1'b1;
               next_state   = st_done;
            end else begin
               ev_miss    = 1'b1;
               // lines hold one word so a write miss never needs a fetch
               next_state = victim_dirty ? st_writeback_wait : st_fill;
            end
         end

         st_writeback_wait: begin
            if (!mem_sent && !mem_stall)
               mem_wr = 1'b1;
            if (mem_ready)
               next_state = op_rd ? st_fetch_wait : st_fill;
         end

         st_fetch_wait: begin
            if (!mem_sent && !mem_stall)
               mem_rd = 1'b1;
            if (mem_ready)
               next_state = st_fill;
         end

         st_fill: begin
            arr.write    = 1'b1;
            arr.valid_in = 1'b1;
            arr.dirty_in = !op_rd;               // written lines differ from memory
            next_state   = st_done;
         end

         st_done: begin
            done       = 1'b1;
            next_state = st_idle;
         end

         default: next_state = st_idle;
      endcase
   end

   a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      done |=> !done);

   // memory back-pressure must be honoured
   a_no_strobe_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
      (mem_rd || mem_wr) |-> !mem_stall);

   a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
      !(mem_rd && mem_wr));

endmodule

/* cache_top.sv */
`timescale 1ns/1ns
module cache_top import cache_pkg::*; #(
   parameter int MEM_LAT = 4
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              rd,
   input  logic              wr,
   input  logic [addr_w-1:0] addr,
   input  data_t             wdata,
   output data_t             rdata,
   output logic              done,
   output logic              was_hit,
   output perf_cnt_t         hit_cnt,
   output perf_cnt_t         miss_cnt,
   output perf_cnt_t         wb_cnt
);

   cache_addr_u cpu_addr;
   cache_addr_u mem_addr;
   data_t       mem_wdata;
   data_t       mem_rdata;
   logic        mem_rd;
   logic        mem_wr;
   logic        mem_stall;
   logic        ev_hit;
   logic        ev_miss;
   logic        ev_wb;

   cache_array_if arr_if ();

   assign cpu_addr.raw = addr;

   cache_ctrl u_ctrl (
      .clk       (clk),
      .arst_n    (arst_n),
      .rd        (rd),
      .wr        (wr),
      .addr      (cpu_addr),
      .wdata     (wdata),
      .rdata     (rdata),
      .done      (done),
      .was_hit   (was_hit),
      .arr       (arr_if.ctrl),
      .mem_rd    (mem_rd),
      .mem_wr    (mem_wr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata),
      .mem_stall (mem_stall),
      .ev_hit    (ev_hit),
      .ev_miss   (ev_miss),
      .ev_wb     (ev_wb)
   );

   cache_array u_array (
      .clk    (clk),
      .arst_n (arst_n),
      .arr    (arr_if.array)
   );

   backing_mem #(
      .MEM_LAT (MEM_LAT)
   ) u_mem (
      .clk       (clk),
      .arst_n    (arst_n),
      .mem_rd    (mem_rd),
      .mem_wr    (mem_wr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata),
      .mem_stall (mem_stall)
   );

   cache_perf u_perf (
      .clk      (clk),
      .arst_n   (arst_n),
      .ev_hit   (ev_hit),
      .ev_miss  (ev_miss),
      .ev_wb    (ev_wb),
      .hit_cnt  (hit_cnt),
      .miss_cnt (miss_cnt),
      .wb_cnt   (wb_cnt)
   );

endmodule

/* tb_cache.sv */
`timescale 1ns/1ns
module tb_cache import cache_pkg::*; ();

   localparam int mem_lat     = 3;
   localparam int num_rand    = 300;
   localparam int num_req     = num_rand + 6;
   localparam int worst_cyc   = 3 + 1 + 2 * (mem_lat + 2) + 2;   // issue, compare, wb, fetch, fill
   localparam int reset_cyc   = 10;
   localparam int timeout_cyc = reset_cyc + num_req * worst_cyc + 200;
   localparam int num_lines   = 2**index_w;

   typedef struct packed {
      data_t       data;
      logic        hit;
      logic        is_rd;
      logic [31:0] acc;      // cycle of the accepting edge
   } exp_t;

   logic              clk;
   logic              arst_n;
   logic              rd;
   logic              wr;
   logic [addr_w-1:0] addr;
   data_t             wdata;
   data_t             rdata;
   logic              done;
   logic              was_hit;
   perf_cnt_t         hit_cnt;
   perf_cnt_t         miss_cnt;
   perf_cnt_t         wb_cnt;

   int     cycles;
   int     req_num;
   int     data_errs;
   int     hit_errs;
   int     lat_errs;
   int     cnt_errs;
   int     proto_errs;
   integer seed;
   exp_t   exp_q [$];

   // reference model state
   data_t            ref_mem [int];        // unwritten words read back as their address
   logic [tag_w-1:0] ref_tag [num_lines];
   logic             ref_valid [num_lines];
   logic             ref_dirty [num_lines];
   perf_cnt_t        ref_hits;
   perf_cnt_t        ref_misses;
   perf_cnt_t        ref_wbs;

   cache_top #(
      .MEM_LAT (mem_lat)
   ) dut0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .rd       (rd),
      .wr       (wr),
      .addr     (addr),
      .wdata    (wdata),
      .rdata    (rdata),
      .done     (done),
      .was_hit  (was_hit),
      .hit_cnt  (hit_cnt),
      .miss_cnt (miss_cnt),
      .wb_cnt   (wb_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // expected result of one access and its effect on the model
   function automatic void ref_access(input logic is_rd, input logic [addr_w-1:0] a,
                                      input data_t wd, output data_t exp_data,
                                      output logic exp_hit);
      logic [index_w-1:0] idx;
      logic [tag_w-1:0]   tg;
      idx     = a[index_w-1:0];
      tg      = a[addr_w-1:index_w];
      exp_hit = ref_valid[idx] && (ref_tag[idx] == tg);
      if (exp_hit) begin
         ref_hits++;
      end else begin
         ref_misses++;
         if (ref_valid[idx] && ref_dirty[idx])
            ref_wbs++;                           // dirty victim goes back to memory
         ref_tag[idx]   = tg;
         ref_valid[idx] = 1'b1;
         ref_dirty[idx] = 1'b0;
      end
      if (!is_rd) begin
         ref_mem[int'(a)] = wd;
         ref_dirty[idx]   = 1'b1;
      end
      exp_data = ref_mem.exists(int'(a)) ? ref_mem[int'(a)] : data_t'(a);
   endfunction

   task automatic check_data(input data_t got, input data_t exp, input string what);
      if (got !== exp) begin
         data_errs++;
         $display("CHECK FAILED at %0t: %s rdata %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_hit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         hit_errs++;
         $display("CHECK FAILED at %0t: %s was_hit %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_latency(input int got, input int exp, input string what);
      if (got != exp) begin
         lat_errs++;
         $display("CHECK FAILED at %0t: %s hit latency %0d expected %0d",
                  $time, what, got, exp);
      end
   endtask

   task automatic check_count(input perf_cnt_t got, input perf_cnt_t exp, input string what);
      if (got !== exp) begin
         cnt_errs++;
         $display("CHECK FAILED at %0t: %s %0d expected %0d", $time, what, got, exp);
      end
   endtask

   // one request held for a single cycle and then a wait for done
   task automatic issue(input logic is_rd, input logic [addr_w-1:0] a, input data_t wd);
      exp_t  e;
      data_t ed;
      logic  eh;
      @(posedge clk);
      rd    <= is_rd;
      wr    <= !is_rd;
      addr  <= a;
      wdata <= wd;
      @(posedge clk);                           // accepting edge
      rd <= 1'b0;
      wr <= 1'b0;
      ref_access(is_rd, a, wd, ed, eh);
      e.data  = ed;
      e.hit   = eh;
      e.is_rd = is_rd;
      e.acc   = cycles;
      exp_q.push_back(e);
      do
         @(negedge clk);
      while (!done);
   endtask

   // compare at mid-cycle where done and rdata are stable
   always @(negedge clk) begin
      exp_t  e;
      string what;
      if (arst_n && done) begin
         if (exp_q.size() == 0) begin
            proto_errs++;
            $display("error at %0t: done was raised with no request outstanding", $time);
         end else begin
            e    = exp_q.pop_front();
            what = $sformatf("request %0d", req_num);
            req_num++;
            if (e.is_rd)
               check_data(rdata, e.data, what);  // rdata is only defined for reads
            check_hit(was_hit, e.hit, what);
            if (e.hit)
               check_latency(cycles - int'(e.acc), 2, what);
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cyc) begin
         $display("timeout: run did not finish within %0d cycles", timeout_cyc);
         $display("TB FAILED");
         $finish;
      end
   end

   initial begin
      int               r;
      int               total;
      logic             is_rd;
      logic [addr_w-1:0] a;
      data_t            wd;
      rd         = 1'b0;
      wr         = 1'b0;
      addr       = '0;
      wdata      = '0;
      arst_n     = 1'b0;
      cycles     = 0;
      req_num    = 0;
      data_errs  = 0;
      hit_errs   = 0;
      lat_errs   = 0;
      cnt_errs   = 0;
      proto_errs = 0;
      seed       = 43697;
      ref_hits   = '0;
      ref_misses = '0;
      ref_wbs    = '0;
      for (int i = 0; i < num_lines; i++) begin
         ref_valid[i] = 1'b0;
         ref_dirty[i] = 1'b0;
         ref_tag[i]   = '0;
      end

      repeat (reset_cyc) @(posedge clk);
      arst_n <= 1'b1;
      repeat (2) @(posedge clk);

      issue(1'b1, 16'h1234, '0);                // cold read
      issue(1'b0, 16'h0040, 16'hbeef);
      issue(1'b1, 16'h0040, '0);                // read hit after write
      issue(1'b0, 16'h0101, 16'haaaa);          // index 1, tag 4
      issue(1'b0, 16'h0201, 16'hbbbb);          // same index, tag 8
      issue(1'b1, 16'h0101, '0);                // write-back then refetch

      // 4 tags over 16 indexes keeps conflicts frequent
      for (int n = 0; n < num_rand; n++) begin
         r     = $random(seed);
         is_rd = r[16];
         a     = (addr_w'(r[9:8]) << index_w) | addr_w'(r[7:4]);
         wd    = data_t'($random(seed));
         issue(is_rd, a, is_rd ? '0 : wd);
      end

      repeat (3) @(posedge clk);                // counters trail their pulses by a cycle
      check_count(hit_cnt, ref_hits, "hit_cnt");
      check_count(miss_cnt, ref_misses, "miss_cnt");
      check_count(wb_cnt, ref_wbs, "wb_cnt");

      total = data_errs + hit_errs + lat_errs + cnt_errs + proto_errs;
      $display("errors: data %0d hit %0d latency %0d count %0d protocol %0d",
               data_errs, hit_errs, lat_errs, cnt_errs, proto_errs);
      if (total == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

/* filelist.f */
cache_pkg.sv
cache_array_if.sv
cache_array.sv
backing_mem.sv
cache_perf.sv
cache_ctrl.sv
cache_top.sv
tb_cache.sv

/* Makefile */
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_cache
RTL_TOP   ?= cache_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass or fail comes from the printed result line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
